//--- common/frontend_pkg.sv
`default_nettype none

package frontend_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    // virtual address width
    localparam int unsigned VLEN = 32;
    // one uncompressed instruction
    localparam int unsigned ILEN = 32;

    typedef logic [VLEN-1:0] addr_t;

    // control flow class of one fetched instruction
    typedef enum logic [2:0] {
        NoCf,
        Branch,
        Jump,
        JumpR,
        Return
    } cf_t;

    // ----------------------------------------
    // memory side
    // ----------------------------------------
    typedef struct packed {
        logic  req;
        addr_t vaddr;
    } fetch_req_t;

    // answer arrives one cycle after the accepted request
    typedef struct packed {
        logic            valid;
        addr_t           vaddr;
        logic [ILEN-1:0] data;
    } fetch_rsp_t;

    // ----------------------------------------
    // back end side
    // ----------------------------------------
    typedef struct packed {
        addr_t           pc;
        logic [ILEN-1:0] instr;
        cf_t             cf;
        logic            taken;
        addr_t           predict_addr;
    } fetch_entry_t;

    // branch outcome from execute, also carries the mispredict redirect
    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_branch;
        logic  taken;
        logic  mispredict;
        addr_t target;
    } resolve_t;

    // ----------------------------------------
    // prediction internals
    // ----------------------------------------
    typedef struct packed {
        logic  is_branch;
        logic  is_jump;
        logic  is_jalr;
        logic  is_call;
        logic  is_return;
        addr_t imm;
    } scan_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bht_pred_t;

    typedef struct packed {
        logic  valid;
        addr_t ra;
    } ras_t;

endpackage

`default_nettype wire

//--- bpred/instr_scan.sv
`timescale 1ns/1ps
`default_nettype none

module instr_scan (
    input  wire [frontend_pkg::ILEN-1:0] instr_i,
    output frontend_pkg::scan_t          scan_o
);

    // rv32 major opcodes for control flow
    localparam logic [6:0] OpBranch = 7'b1100011;
    localparam logic [6:0] OpJal    = 7'b1101111;
    localparam logic [6:0] OpJalr   = 7'b1100111;

    logic [6:0] opcode;
    logic [4:0] rd, rs1;
    logic is_branch, is_jal, is_jalr;
    logic rd_link, rs1_link;
    frontend_pkg::addr_t imm_b, imm_j;

    assign opcode = instr_i[6:0];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    assign is_branch = (opcode == OpBranch);
    assign is_jal    = (opcode == OpJal);
    assign is_jalr   = (opcode == OpJalr);

    // x1 and x5 are the link registers of the calling convention
    assign rd_link  = (rd == 5'd1) || (rd == 5'd5);
    assign rs1_link = (rs1 == 5'd1) || (rs1 == 5'd5);

    // ----------------------------------------
    // immediates
    // ----------------------------------------
    // b-type, bit 0 always zero
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                    instr_i[30:25], instr_i[11:8], 1'b0};
    // j-type
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                    instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        scan_o.is_branch = is_branch;
        scan_o.is_jump   = is_jal;
        scan_o.is_jalr   = is_jalr;
        // call links through x1/x5, for jal as well as jalr
        scan_o.is_call   = (is_jal || is_jalr) && rd_link;
        // return jumps through a link register and discards the link
        scan_o.is_return = is_jalr && rs1_link && (rd == 5'd0);
        scan_o.imm       = is_branch ? imm_b : imm_j;
    end

endmodule

`default_nettype wire

//--- bpred/bht.sv
`timescale 1ns/1ps
`default_nettype none

module bht #(
    parameter int unsigned BhtEntries = 64
) (
    input  wire                       clk_i,
    input  wire                       rst_ni,
    input  frontend_pkg::addr_t       pc_i,
    input  frontend_pkg::resolve_t    update_i,
    output frontend_pkg::bht_pred_t   pred_o
);

    localparam int unsigned IdxW = $clog2(BhtEntries);

    logic [BhtEntries-1:0] valid_q;
    logic [1:0] cnt_q [BhtEntries];
    logic [IdxW-1:0] rd_idx, up_idx;
    logic up_en;

    // index skips the two byte offset bits of a word
    assign rd_idx = pc_i[IdxW+1:2];
    assign up_idx = update_i.pc[IdxW+1:2];
    assign up_en  = update_i.valid & update_i.is_branch;

    // combinational read, msb of the counter is the direction
    assign pred_o.valid = valid_q[rd_idx];
    assign pred_o.taken = cnt_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (up_en) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    // ----------------------------------------
    // 2-bit saturating counters
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (up_en) begin
            if (!valid_q[up_idx]) begin
                // fresh entry, weak state in the direction just seen
                cnt_q[up_idx] <= update_i.taken ? 2'b10 : 2'b01;
            end else if (update_i.taken && cnt_q[up_idx] != 2'b11) begin
                cnt_q[up_idx] <= cnt_q[up_idx] + 2'd1;
            end else if (!update_i.taken && cnt_q[up_idx] != 2'b00) begin
                cnt_q[up_idx] <= cnt_q[up_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- bpred/ras.sv
`timescale 1ns/1ps
`default_nettype none

module ras #(
    parameter int unsigned RasDepth = 4
) (
    input  wire                  clk_i,
    input  wire                  rst_ni,
    input  wire                  push_i,
    input  wire                  pop_i,
    input  frontend_pkg::addr_t  data_i,
    output frontend_pkg::ras_t   top_o
);

    // slot 0 is the top of stack
    frontend_pkg::ras_t [RasDepth-1:0] stack_d, stack_q;

    assign top_o = stack_q[0];

    always_comb begin
        stack_d = stack_q;
        if (push_i && pop_i) begin
            // return and call in one go, just swap the top
            stack_d[0] = '{valid: 1'b1, ra: data_i};
        end else if (push_i) begin
            // shift down, the oldest entry falls off the bottom
            for (int i = RasDepth - 1; i > 0; i--) begin
                stack_d[i] = stack_q[i-1];
            end
            stack_d[0] = '{valid: 1'b1, ra: data_i};
        end else if (pop_i) begin
            for (int i = 0; i < RasDepth - 1; i++) begin
                stack_d[i] = stack_q[i+1];
            end
            stack_d[RasDepth-1] = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stack_q <= '0;
        end else begin
            stack_q <= stack_d;
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> stack_q[0].valid)
        else $error("RAS pop while empty");

endmodule

`default_nettype wire

//--- verilog/fetch_queue.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int unsigned QueueDepth = 4
) (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  wire                        flush_i,
    input  wire                        push_i,
    input  frontend_pkg::fetch_entry_t entry_i,
    output logic                       room_o,
    output frontend_pkg::fetch_entry_t entry_o,
    output logic                       valid_o,
    input  wire                        ready_i
);

    localparam int unsigned PtrW = $clog2(QueueDepth);
    localparam int unsigned CntW = PtrW + 1;

    frontend_pkg::fetch_entry_t mem_q [QueueDepth];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_idx;
    logic [CntW-1:0] count_q;
    logic [CntW-1:0] wr_sum;
    logic pop;

    // write slot sits count entries past the read pointer
    assign wr_sum = CntW'(rd_ptr_q) + count_q;
    assign wr_idx = (wr_sum >= CntW'(QueueDepth)) ? PtrW'(wr_sum - CntW'(QueueDepth))
                                                  : PtrW'(wr_sum);

    assign valid_o = (count_q != '0);
    assign entry_o = mem_q[rd_ptr_q];
    assign pop     = valid_o & ready_i;
    assign room_o  = (count_q <= CntW'(QueueDepth - 2));

    // payload storage
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_idx] <= entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together keep the count
            count_q <= count_q + CntW'(push_i) - CntW'(pop);
        end
    end

    // the request gating upstream must keep a slot for every response
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        push_i |-> count_q != CntW'(QueueDepth))
        else $error("push into full fetch queue");

endmodule

`default_nettype wire

//--- verilog/next_pc_select.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_select (
    input  wire                       clk_i,
    input  wire                       rst_ni,
    input  frontend_pkg::addr_t       boot_addr_i,
    input  wire                       set_pc_commit_i,
    input  frontend_pkg::addr_t       pc_commit_i,
    input  wire                       ex_valid_i,
    input  frontend_pkg::addr_t       trap_vector_i,
    input  wire                       eret_i,
    input  frontend_pkg::addr_t       epc_i,
    input  frontend_pkg::resolve_t    resolve_i,
    input  wire                       rsp_valid_i,
    input  frontend_pkg::addr_t       rsp_pc_i,
    input  frontend_pkg::scan_t       scan_i,
    input  frontend_pkg::bht_pred_t   bht_i,
    input  frontend_pkg::ras_t        ras_i,
    input  wire                       queue_room_i,
    input  wire                       fetch_ready_i,
    output frontend_pkg::fetch_req_t  fetch_req_o,
    output frontend_pkg::cf_t         entry_cf_o,
    output logic                      entry_taken_o,
    output frontend_pkg::addr_t       entry_target_o,
    output logic                      ras_push_o,
    output logic                      ras_pop_o,
    output frontend_pkg::addr_t       ras_data_o,
    output logic                      redirect_o
);

    frontend_pkg::addr_t npc_d, npc_q;
    frontend_pkg::addr_t fetch_addr;
    frontend_pkg::addr_t pred_addr;
    frontend_pkg::addr_t seq_addr;
    logic boot_load_q;
    logic mispredict, redirect;
    logic cf_valid, bp_valid;
    logic req;

    assign mispredict = resolve_i.valid & resolve_i.mispredict;
    assign redirect   = set_pc_commit_i | ex_valid_i | eret_i | mispredict;
    assign redirect_o = redirect;
    // a response on the old path must not touch the RAS
    assign cf_valid   = rsp_valid_i & ~redirect;
    assign seq_addr   = rsp_pc_i + 32'd4;
    assign ras_data_o = seq_addr;

    // ----------------------------------------
    // taken / not taken
    // ----------------------------------------
    always_comb begin : predict
        entry_cf_o    = frontend_pkg::NoCf;
        entry_taken_o = 1'b0;
        pred_addr     = rsp_pc_i + scan_i.imm;
        ras_pop_o     = 1'b0;
        if (scan_i.is_branch) begin
            entry_cf_o = frontend_pkg::Branch;
            // no history yet: backward taken, forward not taken
            entry_taken_o = bht_i.valid ? bht_i.taken : scan_i.imm[frontend_pkg::VLEN-1];
        end else if (scan_i.is_jump) begin
            entry_cf_o    = frontend_pkg::Jump;
            entry_taken_o = 1'b1;
        end else if (scan_i.is_return) begin
            entry_cf_o    = frontend_pkg::Return;
            entry_taken_o = ras_i.valid;
            pred_addr     = ras_i.ra;
            ras_pop_o     = cf_valid & ras_i.valid;
        end else if (scan_i.is_jalr) begin
            // target unknown, fetch just falls through
            entry_cf_o = frontend_pkg::JumpR;
        end
        ras_push_o = cf_valid & scan_i.is_call;
    end

    assign entry_target_o = entry_taken_o ? pred_addr : seq_addr;
    assign bp_valid       = cf_valid & entry_taken_o;

    // ----------------------------------------
    // request and next pc
    // ----------------------------------------
    assign fetch_addr = boot_load_q ? boot_addr_i : npc_q;
    // two free slots cover the response already in flight
    assign req = ~boot_load_q & queue_room_i & ~redirect & ~bp_valid;
    assign fetch_req_o.req   = req;
    assign fetch_req_o.vaddr = fetch_addr;

    // lowest priority first, later lines win
    always_comb begin : npc_select
        npc_d = fetch_addr;
        if (req && fetch_ready_i) npc_d = fetch_addr + 32'd4;
        if (bp_valid) npc_d = pred_addr;
        if (mispredict) npc_d = resolve_i.target;
        if (eret_i) npc_d = epc_i;
        if (ex_valid_i) npc_d = trap_vector_i;
        if (set_pc_commit_i) npc_d = pc_commit_i + 32'd4;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q <= 1'b1;
            npc_q       <= '0;
        end else begin
            boot_load_q <= 1'b0;
            npc_q       <= npc_d;
        end
    end

    // targets from scan, RAS and back end all stay word aligned
    assert property (@(posedge clk_i) disable iff (!rst_ni) npc_d[1:0] == 2'b00)
        else $error("next pc not word aligned");

endmodule

`default_nettype wire

//--- verilog/fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend #(
    parameter int unsigned BhtEntries = 64,
    parameter int unsigned RasDepth   = 4,
    parameter int unsigned QueueDepth = 4
) (
    input  wire                        clk_i,
    input  wire                        rst_ni,
    input  frontend_pkg::addr_t        boot_addr_i,
    // redirects from the back end
    input  wire                        set_pc_commit_i,
    input  frontend_pkg::addr_t        pc_commit_i,
    input  wire                        ex_valid_i,
    input  frontend_pkg::addr_t        trap_vector_i,
    input  wire                        eret_i,
    input  frontend_pkg::addr_t        epc_i,
    input  frontend_pkg::resolve_t     resolve_i,
    // instruction memory
    output frontend_pkg::fetch_req_t   fetch_req_o,
    input  wire                        fetch_ready_i,
    input  frontend_pkg::fetch_rsp_t   fetch_rsp_i,
    // toward decode
    output frontend_pkg::fetch_entry_t fetch_entry_o,
    output logic                       fetch_valid_o,
    input  wire                        fetch_ready_i_be
);

    frontend_pkg::scan_t        scan;
    frontend_pkg::bht_pred_t    bht_pred;
    frontend_pkg::ras_t         ras_top;
    frontend_pkg::cf_t          entry_cf;
    frontend_pkg::addr_t        entry_target;
    frontend_pkg::addr_t        ras_data;
    frontend_pkg::fetch_entry_t queue_in;
    logic entry_taken;
    logic ras_push, ras_pop;
    logic queue_room;
    logic redirect;
    logic stale_q;
    logic rsp_ok;

    // the response right after a redirect belongs to the old path
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            stale_q <= 1'b0;
        end else begin
            stale_q <= redirect;
        end
    end

    assign rsp_ok = fetch_rsp_i.valid & ~stale_q;

    // ----------------------------------------
    // next pc and prediction
    // ----------------------------------------
    next_pc_select next_pc_select_inst (
        .clk_i, .rst_ni, .boot_addr_i,
        .set_pc_commit_i, .pc_commit_i,
        .ex_valid_i, .trap_vector_i,
        .eret_i, .epc_i, .resolve_i,
        .rsp_valid_i    (rsp_ok),
        .rsp_pc_i       (fetch_rsp_i.vaddr),
        .scan_i         (scan),
        .bht_i          (bht_pred),
        .ras_i          (ras_top),
        .queue_room_i   (queue_room),
        .fetch_ready_i,
        .fetch_req_o,
        .entry_cf_o     (entry_cf),
        .entry_taken_o  (entry_taken),
        .entry_target_o (entry_target),
        .ras_push_o     (ras_push),
        .ras_pop_o      (ras_pop),
        .ras_data_o     (ras_data),
        .redirect_o     (redirect)
    );

    instr_scan instr_scan_inst (.instr_i(fetch_rsp_i.data), .scan_o(scan));

    // indexed by the pc of the returning instruction
    bht #(.BhtEntries(BhtEntries)) bht_inst (
        .clk_i, .rst_ni,
        .pc_i     (fetch_rsp_i.vaddr),
        .update_i (resolve_i),
        .pred_o   (bht_pred)
    );

    ras #(.RasDepth(RasDepth)) ras_inst (
        .clk_i, .rst_ni,
        .push_i (ras_push),
        .pop_i  (ras_pop),
        .data_i (ras_data),
        .top_o  (ras_top)
    );

    // ----------------------------------------
    // fetch queue
    // ----------------------------------------
    assign queue_in = '{pc: fetch_rsp_i.vaddr, instr: fetch_rsp_i.data, cf: entry_cf,
                        taken: entry_taken, predict_addr: entry_target};

    fetch_queue #(.QueueDepth(QueueDepth)) fetch_queue_inst (
        .clk_i, .rst_ni,
        .flush_i (redirect),
        // nothing from the old path enters once a redirect is seen
        .push_i  (rsp_ok & ~redirect),
        .entry_i (queue_in),
        .room_o  (queue_room),
        .entry_o (fetch_entry_o),
        .valid_o (fetch_valid_o),
        .ready_i (fetch_ready_i_be)
    );

endmodule

`default_nettype wire

//--- dv/tb_fetch_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    frontend_pkg::addr_t boot_addr_i = 32'h1000;
    logic set_pc_commit_i = 1'b0, ex_valid_i = 1'b0, eret_i = 1'b0;
    frontend_pkg::addr_t pc_commit_i = '0, trap_vector_i = '0, epc_i = '0;
    frontend_pkg::resolve_t resolve_i = '0;
    frontend_pkg::fetch_req_t fetch_req_o;
    logic fetch_ready_i = 1'b0;
    frontend_pkg::fetch_rsp_t fetch_rsp_i = '0;
    frontend_pkg::fetch_entry_t fetch_entry_o;
    logic fetch_valid_o;
    logic fetch_ready_i_be = 1'b0;

    logic [31:0] prog [logic [31:0]];
    logic [31:0] rng = 32'h68ad;
    logic acc_q = 1'b0;
    frontend_pkg::addr_t acc_addr = '0;
    frontend_pkg::addr_t exp_pc = 32'h1000;
    frontend_pkg::addr_t ras_model [$];
    logic [63:0] bht_valid = '0;
    logic [1:0] bht_cnt [64];
    int be_mode = 0;
    int n_checked = 0;
    int err_count = 0;

    fetch_frontend fetch_frontend_inst (.*);

    always #4 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // unknown words decode as op-imm with payload bits taken from the whole address
    function automatic logic [31:0] mem_read(input logic [31:0] a);
        if (prog.exists(a)) return prog[a];
        return {a[31:7] ^ a[24:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        return {12'd0, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    // beq x0, x0 with a b-type offset
    function automatic logic [31:0] enc_beq(input logic [31:0] imm);
        return {imm[12], imm[10:5], 10'd0, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // ----------------------------------------
    // reference prediction
    // ----------------------------------------
    function automatic frontend_pkg::fetch_entry_t ref_predict(input logic [31:0] pc,
                                                              input logic [31:0] instr);
        frontend_pkg::fetch_entry_t r;
        logic [31:0] imm;
        logic [4:0] rd, rs1;
        rd = instr[11:7];
        rs1 = instr[19:15];
        r = '{pc: pc, instr: instr, cf: frontend_pkg::NoCf, taken: 1'b0,
              predict_addr: pc + 32'd4};
        if (instr[6:0] == 7'b1100011) begin
            imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            r.cf = frontend_pkg::Branch;
            r.taken = bht_valid[pc[7:2]] ? bht_cnt[pc[7:2]][1] : imm[31];
            if (r.taken) r.predict_addr = pc + imm;
        end else if (instr[6:0] == 7'b1101111) begin
            imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            r.cf = frontend_pkg::Jump;
            r.taken = 1'b1;
            r.predict_addr = pc + imm;
        end else if (instr[6:0] == 7'b1100111) begin
            if ((rs1 == 5'd1 || rs1 == 5'd5) && rd == 5'd0) begin
                r.cf = frontend_pkg::Return;
                r.taken = (ras_model.size() > 0);
                if (r.taken) r.predict_addr = ras_model[0];
            end else begin
                r.cf = frontend_pkg::JumpR;
            end
        end
        return r;
    endfunction

    // memory answers one cycle after acceptance and drops ready at random
    always @(negedge clk_i) begin
        acc_q <= fetch_req_o.req & fetch_ready_i;
        acc_addr <= fetch_req_o.vaddr;
    end

    always @(posedge clk_i) begin
        rng = lcg_next(rng);
        fetch_ready_i <= rst_ni & (rng[17:16] != 2'b00);
        if (acc_q) begin
            fetch_rsp_i <= '{valid: 1'b1, vaddr: acc_addr, data: mem_read(acc_addr)};
        end else begin
            fetch_rsp_i <= '0;
        end
        fetch_ready_i_be <= (be_mode == 1) || (be_mode == 2 && rng[21]);
    end

    // ----------------------------------------
    // checker for every entry the back end takes
    // ----------------------------------------
    always @(negedge clk_i) begin : check_entries
        frontend_pkg::fetch_entry_t r;
        logic [4:0] rd;
        if (rst_ni && fetch_valid_o && fetch_ready_i_be) begin
            r = ref_predict(exp_pc, mem_read(exp_pc));
            if (fetch_entry_o !== r) begin
                $display("ERR %0t: pc %h cf %0d taken %b target %h, expected %h %0d %b %h",
                         $time, fetch_entry_o.pc, fetch_entry_o.cf,
                         fetch_entry_o.taken, fetch_entry_o.predict_addr, r.pc, r.cf,
                         r.taken, r.predict_addr);
                err_count++;
            end
            // ras model follows the same pop then push order
            rd = r.instr[11:7];
            if (r.cf == frontend_pkg::Return && r.taken) void'(ras_model.pop_front());
            if ((r.cf == frontend_pkg::Jump || r.instr[6:0] == 7'b1100111) &&
                (rd == 5'd1 || rd == 5'd5)) ras_model.push_front(r.pc + 32'd4);
            if (ras_model.size() > 4) void'(ras_model.pop_back());
            exp_pc = r.predict_addr;
            n_checked++;
        end
    end

    // the idle count restarts with every entry that arrives
    task automatic wait_entries(input int n);
        int goal;
        int seen;
        int idle;
        goal = n_checked + n;
        seen = n_checked;
        idle = 0;
        while (n_checked < goal && idle < 200) begin
            @(posedge clk_i);
            if (n_checked != seen) begin
                seen = n_checked;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (n_checked < goal) begin
            $display("timeout: no fetch entry accepted within 200 cycles");
            $display("Checks failed");
            $finish;
        end
    endtask

    task automatic set_mode(input int m);
        @(negedge clk_i);
        be_mode = m;
    endtask

    // one-cycle pulse of the back-end redirects while the back end holds off
    task automatic redirect(input logic c, input logic x, input logic e, input logic m,
                            input logic [31:0] tgt, input logic [31:0] expect_pc);
        set_mode(0);
        @(posedge clk_i);
        set_pc_commit_i <= c;
        ex_valid_i <= x;
        eret_i <= e;
        pc_commit_i <= 32'h5000;
        trap_vector_i <= tgt;
        epc_i <= 32'h7000;
        resolve_i <= '{valid: m, pc: '0, is_branch: 1'b0, taken: 1'b1, mispredict: 1'b1,
                       target: m ? tgt : 32'h8000};
        exp_pc = expect_pc;
        @(posedge clk_i);
        {set_pc_commit_i, ex_valid_i, eret_i} <= 3'b000;
        resolve_i <= '0;
    endtask

    task automatic report(input int num, input string name);
        $display("test %0d %s done, %0d errors so far", num, name, err_count);
    endtask

    initial begin
        prog[32'h2000] = enc_jal(5'd0, 32'd16);
        prog[32'h2008] = enc_beq(32'd12);
        prog[32'h2010] = enc_beq(32'hffff_fff8);
        prog[32'h2014] = enc_jal(5'd0, 32'hffff_fff4);
        prog[32'h4000] = enc_jal(5'd1, 32'h100);
        prog[32'h4100] = enc_jal(5'd1, 32'h100);
        prog[32'h4200] = enc_jal(5'd5, 32'h100);
        prog[32'h4300] = enc_jal(5'd1, 32'h100);
        prog[32'h4400] = enc_jalr(5'd0, 5'd1);
        prog[32'h4304] = enc_jalr(5'd0, 5'd1);
        prog[32'h4204] = enc_jalr(5'd0, 5'd5);
        prog[32'h4104] = enc_jalr(5'd0, 5'd1);
        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;
        set_mode(1);
        wait_entries(8);
        report(1, "boot and straight line");

        redirect(1'b0, 1'b1, 1'b0, 1'b0, 32'h2000, 32'h2000);
        set_mode(1);
        wait_entries(10);
        report(2, "static prediction");

        // train the forward branch at 0x2008 as taken twice
        set_mode(0);
        @(posedge clk_i);
        resolve_i <= '{valid: 1'b1, pc: 32'h2008, is_branch: 1'b1, taken: 1'b1,
                       mispredict: 1'b0, target: 32'h2014};
        bht_valid[2] = 1'b1;
        bht_cnt[2] = 2'b10;
        @(posedge clk_i);
        bht_cnt[2] = 2'b11;
        @(posedge clk_i);
        resolve_i <= '0;
        redirect(1'b0, 1'b0, 1'b0, 1'b1, 32'h2008, 32'h2008);
        set_mode(1);
        wait_entries(6);
        report(3, "bht training");

        redirect(1'b0, 1'b1, 1'b0, 1'b0, 32'h4000, 32'h4000);
        set_mode(1);
        wait_entries(12);
        report(4, "nested calls and returns");

        redirect(1'b1, 1'b1, 1'b1, 1'b1, 32'h6000, 32'h5004);
        set_mode(1);
        wait_entries(5);
        report(5, "redirect priority");

        redirect(1'b0, 1'b1, 1'b0, 1'b0, 32'h4000, 32'h4000);
        set_mode(2);
        wait_entries(40);
        report(6, "random back-pressure");

        $display("entries checked %0d, errors %0d", n_checked, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/frontend_pkg.sv
bpred/instr_scan.sv
bpred/bht.sv
bpred/ras.sv
verilog/fetch_queue.sv
verilog/next_pc_select.sv
verilog/fetch_frontend.sv
dv/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - common/frontend_pkg.sv
  - bpred/instr_scan.sv
  - bpred/bht.sv
  - bpred/ras.sv
  - verilog/fetch_queue.sv
  - verilog/next_pc_select.sv
  - verilog/fetch_frontend.sv
  - target: test
    files:
      - dv/tb_fetch_frontend.sv
